/* run_sim.sh */
#!/bin/sh
# compile and run the core_net_interface testbench with verilator

cd "$(dirname "$0")" || exit 1

top=tb_core_net_interface
log=sim.log

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module "$top" -f src.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/V"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the testbench prints its fail line on any error or timeout
if grep -q "Some tests failed" "$log"; then
	echo "simulation reported failures, see $log"
	exit 1
fi

echo "simulation finished without failures"
exit 0

/* sim/tb_core_net_interface.sv */
`timescale 1ns/100ps

module tb_core_net_interface;
	import noc_pkg::*;

	localparam int depth = 16;      // flits per fifo
	localparam int limit = 500;     // cycles allowed per wait

	logic   clk;
	logic   reset;
	flit_t  rx_flit;
	logic   rx_wr;
	logic   rx_full;
	word_t  core_rx_word;
	logic   core_rx_valid;
	logic   core_rx_ack;
	word_t  core_tx_word;
	route_t core_tx_route;
	logic   core_tx_last;
	logic   core_tx_valid;
	logic   core_tx_ack;
	flit_t  tx_flit;
	logic   tx_valid;
	logic   tx_rd;

	logic        read_en;           // router drains the tx fifo
	logic        loop_en;           // tx flits fed back into rx
	logic        rx_ack_en;         // core accepts offered words
	logic [31:0] rand_state;
	int          ack_cnt;
	int          ack_base;          // ack count when the current word started
	int          rx_wr_cnt;
	int          mismatch_cnt;
	int          timeout_cnt;
	flit_t       rx_src_q[$];       // flits waiting for the rx fifo
	flit_t       tx_q[$];           // flits read off tx_flit
	flit_t       exp_q[$];
	word_t       exp_words[$];
	word_t       rx_words[$];       // words the core took

	core_net_interface #(.fifo_depth(depth)) DUT (.*);

	always #50 clk = ~clk;          // 100 ns period

	//////////////////////////////////////////////////////////////////////
	// reference packing rules
	//////////////////////////////////////////////////////////////////////

	// ten-bit slice k of a word, msb slice first
	function automatic logic [payload_w-1:0] slice(word_t w, int k);
		return w[(flits_per_word-1-k)*payload_w +: payload_w];
	endfunction

	function automatic word_t rebuild(word_t w);
		return {2'b00, slice(w, 0), slice(w, 1), slice(w, 2)}; // top two never routed
	endfunction

	function automatic flit_t data_flit(word_t w, int k, logic last);
		return {last && k == flits_per_word - 1, slice(w, k)};
	endfunction

	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state ^ (rand_state >> 16); // fold weak low bits
	endfunction

	task automatic check_equal(logic [31:0] got, logic [31:0] exp, string what);
		assert (got === exp) else begin
			mismatch_cnt++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_wait(int n, string what);
		assert (n < limit) else begin
			timeout_cnt++;
			$display("Timed out at %0t ns while waiting for %s", $time, what);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// one clock cycle: sample at negedge, drive just after posedge
	//////////////////////////////////////////////////////////////////////

	task automatic tick();
		@(negedge clk);
		if (tx_valid && tx_rd) begin
			tx_q.push_back(tx_flit);
			if (loop_en) begin
				rx_src_q.push_back(tx_flit);    // router loops it back
			end
		end
		if (core_tx_ack) begin
			ack_cnt++;
		end
		if (core_rx_valid && core_rx_ack) begin
			rx_words.push_back(core_rx_word);   // transfer happens this edge
		end
		@(posedge clk);
		#1;
		tx_rd       = read_en;
		core_rx_ack = rx_ack_en;
		if (rx_src_q.size() > 0 && !rx_full) begin
			rx_flit = rx_src_q.pop_front();
			rx_wr   = 1'b1;
			rx_wr_cnt++;
		end else begin
			rx_wr = 1'b0;
		end
	endtask

	task automatic wait_tx_flits(int cnt);
		int n = 0;
		while (tx_q.size() < cnt && n < limit) begin
			tick();
			n++;
		end
		check_wait(n, "flits on tx_flit");
	endtask

	task automatic wait_rx_words(int cnt);
		int n = 0;
		while (rx_words.size() < cnt && n < limit) begin
			tick();
			n++;
		end
		check_wait(n, "words on core_rx_word");
	endtask

	task automatic start_word(word_t w, route_t r, logic last);
		ack_base      = ack_cnt;
		core_tx_word  = w;
		core_tx_route = r;
		core_tx_last  = last;
		core_tx_valid = 1'b1;
	endtask

	task automatic finish_word();
		int n = 0;
		while (ack_cnt == ack_base && n < limit) begin
			tick();
			n++;
		end
		check_wait(n, "core_tx_ack");
		core_tx_valid = 1'b0;   // serializer is back in idle
	endtask

	task automatic queue_rx_word(word_t w, logic last);
		for (int k = 0; k < flits_per_word; k++) begin
			rx_src_q.push_back(data_flit(w, k, last));
		end
	endtask

	task automatic expect_tx_word(word_t w, logic last);
		for (int k = 0; k < flits_per_word; k++) begin
			exp_q.push_back(data_flit(w, k, last));
		end
	endtask

	task automatic compare_tx(string what);
		check_equal(tx_q.size(), exp_q.size(), {what, " flit count"});
		for (int i = 0; i < exp_q.size() && i < tx_q.size(); i++) begin
			check_equal({21'd0, tx_q[i]}, {21'd0, exp_q[i]}, what);
		end
	endtask

	task automatic compare_rx(string what);
		check_equal(rx_words.size(), exp_words.size(), {what, " word count"});
		for (int i = 0; i < exp_words.size() && i < rx_words.size(); i++) begin
			check_equal(rx_words[i], rebuild(exp_words[i]), what);
		end
	endtask

	task automatic clear_queues();
		tx_q.delete();
		exp_q.delete();
		exp_words.delete();
		rx_words.delete();
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		check_equal(32'(core_rx_valid), 0, "core_rx_valid after reset");
		check_equal(32'(core_tx_ack), 0, "core_tx_ack after reset");
		check_equal(32'(tx_valid), 0, "tx_valid after reset");
		check_equal(32'(rx_full), 0, "rx_full after reset");
	endtask

	task automatic test_one_word_rx();
		word_t  w = next_random() | 32'hc000_0000; // unrouted bits set
		route_t r = route_t'(next_random());
		clear_queues();
		rx_ack_en = 1'b1;
		exp_words.push_back(w);
		rx_src_q.push_back({1'b0, r});
		queue_rx_word(w, 1'b1);
		wait_rx_words(1);
		compare_rx("one-word packet");
		check_equal(32'(core_rx_word[31:30]), 0, "unrouted bits of received word");
	endtask

	task automatic test_rx_backpressure();
		int n = 0;
		int base;
		clear_queues();
		rx_ack_en = 1'b0;               // hold the first word
		base      = rx_wr_cnt;
		rx_src_q.push_back({1'b0, route_t'(next_random())});
		for (int i = 0; i < 6; i++) begin
			exp_words.push_back(next_random());
			if (i >= 3) begin
				rx_src_q.push_back({1'b0, route_t'(next_random())}); // one-word packets
			end
			queue_rx_word(exp_words[i], i >= 2);
		end
		while (!rx_full && n < limit) begin
			tick();
			n++;
		end
		check_wait(n, "rx_full");
		// header and first word popped, the rest pending
		check_equal(rx_wr_cnt - base, depth + 1 + flits_per_word, "flits in when rx_full rose");
		repeat (5) tick();
		check_equal(32'(rx_full), 1, "rx_full while word held");
		check_equal(32'(core_rx_valid), 1, "core_rx_valid while ack withheld");
		rx_ack_en = 1'b1;
		wait_rx_words(6);
		compare_rx("three-word packet");
	endtask

	task automatic test_one_word_tx();
		word_t  w = next_random();
		route_t r = route_t'(next_random());
		clear_queues();
		read_en = 1'b1;
		exp_q.push_back({1'b0, r});
		expect_tx_word(w, 1'b1);
		start_word(w, r, 1'b1);
		finish_word();
		wait_tx_flits(4);
		repeat (5) tick();
		check_equal(ack_cnt - ack_base, 1, "core_tx_ack pulses for one word");
		compare_tx("one-word transmit");
	endtask

	task automatic test_tx_packets();
		word_t  w[3];
		route_t r[2];
		clear_queues();
		read_en = 1'b1;
		for (int i = 0; i < 3; i++) begin
			w[i] = next_random();
		end
		r[0] = route_t'(next_random());
		r[1] = route_t'(next_random());
		exp_q.push_back({1'b0, r[0]});
		expect_tx_word(w[0], 1'b0);
		expect_tx_word(w[1], 1'b1);
		exp_q.push_back({1'b0, r[1]});
		expect_tx_word(w[2], 1'b1);
		start_word(w[0], r[0], 1'b0);
		finish_word();
		start_word(w[1], r[0], 1'b1);   // no second header expected
		finish_word();
		start_word(w[2], r[1], 1'b1);
		finish_word();
		wait_tx_flits(11);
		repeat (5) tick();
		compare_tx("two packets");
		// four one-word packets fill the tx fifo exactly
		clear_queues();
		read_en = 1'b0;
		for (int i = 0; i < 4; i++) begin
			start_word(next_random(), route_t'(next_random()), 1'b1);
			finish_word();
		end
		start_word(w[0], r[0], 1'b1);   // header stuck behind full fifo
		repeat (10) tick();
		check_equal(ack_cnt - ack_base, 0, "core_tx_ack while tx fifo full");
		read_en = 1'b1;
		finish_word();
		wait_tx_flits(20);
		repeat (5) tick();
		check_equal(tx_q.size(), 20, "flits drained after stall");
	endtask

	task automatic test_loopback();
		int left = 0;                   // words still to send in this packet
		clear_queues();
		read_en   = 1'b1;
		loop_en   = 1'b1;
		rx_ack_en = 1'b1;
		for (int i = 0; i < 20; i++) begin
			if (left == 0) begin
				left = int'(next_random() % 4) + 1;
			end
			left--;
			exp_words.push_back(next_random());
			start_word(exp_words[i], route_t'(next_random()), left == 0 || i == 19);
			finish_word();
		end
		wait_rx_words(20);
		repeat (5) tick();
		compare_rx("loopback");
		loop_en = 1'b0;
	endtask

	initial begin
		clk           = 1'b0;
		reset         = 1'b1;
		rx_flit       = '0;
		rx_wr         = 1'b0;
		core_rx_ack   = 1'b0;
		core_tx_word  = '0;
		core_tx_route = '0;
		core_tx_last  = 1'b0;
		core_tx_valid = 1'b0;
		tx_rd         = 1'b0;
		read_en       = 1'b0;
		loop_en       = 1'b0;
		rx_ack_en     = 1'b0;
		rand_state    = 32'd71328;
		ack_cnt       = 0;
		ack_base      = 0;
		rx_wr_cnt     = 0;
		mismatch_cnt  = 0;
		timeout_cnt   = 0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset_state();
		test_one_word_rx();
		test_rx_backpressure();
		test_one_word_tx();
		test_tx_packets();
		test_loopback();
		$display("errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
		if (mismatch_cnt + timeout_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* src.f */
src/noc_pkg.sv
src/flit_fifo.sv
src/flit_deserializer.sv
src/flit_serializer.sv
src/core_net_interface.sv
sim/tb_core_net_interface.sv

/* src/core_net_interface.sv */
`timescale 1ns/100ps

module core_net_interface #(
	parameter int fifo_depth = 16       // flits per fifo
) (
	input  logic            clk,
	input  logic            reset,
	// router to core flits
	input  noc_pkg::flit_t  rx_flit,
	input  logic            rx_wr,
	output logic            rx_full,
	// core receive channel
	output noc_pkg::word_t  core_rx_word,
	output logic            core_rx_valid,
	input  logic            core_rx_ack,
	// core transmit channel
	input  noc_pkg::word_t  core_tx_word,
	input  noc_pkg::route_t core_tx_route,
	input  logic            core_tx_last,
	input  logic            core_tx_valid,
	output logic            core_tx_ack,
	// core to router flits
	output noc_pkg::flit_t  tx_flit,
	output logic            tx_valid,
	input  logic            tx_rd
);
	import noc_pkg::*;

	flit_t rx_head;         // receive fifo head to deserializer
	logic  rx_empty;
	logic  rx_rd;
	flit_t ser_flit;        // serializer into transmit fifo
	logic  ser_wr;
	logic  tx_full;
	logic  tx_empty;

	//////////////////////////////////////////////////////////////////////
	// receive path
	//////////////////////////////////////////////////////////////////////

	flit_fifo #(.fifo_depth(fifo_depth)) rx_fifo (
		.clk     (clk),
		.reset   (reset),
		.wr      (rx_wr),
		.wr_flit (rx_flit),
		.full    (rx_full),
		.rd      (rx_rd),
		.rd_flit (rx_head),
		.empty   (rx_empty)
	);

	flit_deserializer deser (
		.clk        (clk),
		.reset      (reset),
		.flit_empty (rx_empty),
		.flit_in    (rx_head),
		.flit_rd    (rx_rd),
		.word_out   (core_rx_word),
		.word_valid (core_rx_valid),
		.word_ack   (core_rx_ack)
	);

	//////////////////////////////////////////////////////////////////////
	// transmit path
	//////////////////////////////////////////////////////////////////////

	flit_serializer ser (
		.clk        (clk),
		.reset      (reset),
		.word_in    (core_tx_word),
		.route_in   (core_tx_route),
		.last_in    (core_tx_last),
		.word_valid (core_tx_valid),
		.word_ack   (core_tx_ack),
		.flit_out   (ser_flit),
		.flit_wr    (ser_wr),
		.flit_full  (tx_full)
	);

	flit_fifo #(.fifo_depth(fifo_depth)) tx_fifo (
		.clk     (clk),
		.reset   (reset),
		.wr      (ser_wr),
		.wr_flit (ser_flit),
		.full    (tx_full),
		.rd      (tx_rd),           // ignored by the fifo when empty
		.rd_flit (tx_flit),
		.empty   (tx_empty)
	);

	assign tx_valid = !tx_empty;    // head is valid whenever not empty

endmodule

/* src/flit_deserializer.sv */
`timescale 1ns/100ps

module flit_deserializer (
	input  logic           clk,
	input  logic           reset,
	// receive fifo side
	input  logic           flit_empty,
	input  noc_pkg::flit_t flit_in,     // fifo head
	output logic           flit_rd,
	// core side
	output noc_pkg::word_t word_out,
	output logic           word_valid,
	input  logic           word_ack
);
	import noc_pkg::*;

	localparam int routed_w = flits_per_word * payload_w; // 30 bits carried

	deser_state_t        state;
	deser_state_t        next_state;
	logic [routed_w-1:0] word_q;        // assembled payload, no reset
	logic                last_tail;     // tail of the third flit
	logic                pop;

	//////////////////////////////////////////////////////////////////////
	// fifo read
	//////////////////////////////////////////////////////////////////////

	// pop one flit per cycle in every state except while holding
	assign flit_rd = (state != hold_word) && !flit_empty;
	assign pop     = flit_rd;

	always_comb begin
		next_state = state;
		case (state)
			await_header: if (pop) next_state = collect_0; // header dropped
			collect_0:    if (pop) next_state = collect_1;
			collect_1:    if (pop) next_state = collect_2;
			collect_2:    if (pop) next_state = hold_word;
			hold_word: begin
				if (word_ack) begin
					// tail on the last flit means a new header comes next
					next_state = last_tail ? await_header : collect_0;
				end
			end
			default:      next_state = await_header;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state     <= await_header;
			last_tail <= 1'b0;
		end else begin
			state <= next_state;
			if (state == collect_2 && pop) begin
				last_tail <= flit_in.tail;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// word assembly, msb flit first
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (pop) begin
			case (state)
				collect_0: word_q[2*payload_w +: payload_w] <= flit_in.payload; // 29..20
				collect_1: word_q[payload_w +: payload_w]   <= flit_in.payload; // 19..10
				collect_2: word_q[0 +: payload_w]           <= flit_in.payload; // 9..0
				default:   ;                                // header payload ignored
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// core channel
	//////////////////////////////////////////////////////////////////////

	assign word_valid = (state == hold_word);

	// code field, unrouted top bits forced to zero
	assign word_out[word_w-1 -: code_w] =
		{{unrouted_w{1'b0}}, word_q[routed_w-1 -: code_w-unrouted_w]};
	// data field straight from the flits
	assign word_out[word_w-code_w-1:0] = word_q[word_w-code_w-1:0];

endmodule

/* src/flit_fifo.sv */
`timescale 1ns/100ps

module flit_fifo #(
	parameter int fifo_depth = 16                // entries, power of two
) (
	input  logic           clk,
	input  logic           reset,
	// write side
	input  logic           wr,
	input  noc_pkg::flit_t wr_flit,
	output logic           full,
	// read side, head shown ahead of the read
	input  logic           rd,
	output noc_pkg::flit_t rd_flit,
	output logic           empty
);
	import noc_pkg::*;

	localparam int addr_w = $clog2(fifo_depth);

	logic [flit_w-1:0] mem [fifo_depth];        // flit storage, no reset
	logic [addr_w:0]   wr_ptr;                  // extra msb tells wrap
	logic [addr_w:0]   rd_ptr;
	logic              wr_en;
	logic              rd_en;

	// strobes are ignored when they would overrun or underrun
	assign wr_en = wr && !full;
	assign rd_en = rd && !empty;

	//////////////////////////////////////////////////////////////////////
	// pointer compare
	//////////////////////////////////////////////////////////////////////

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
	               (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]); // lapped once

	// head entry, combinational so the reader sees it while !empty
	assign rd_flit = flit_t'(mem[rd_ptr[addr_w-1:0]]);

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr[addr_w-1:0]] <= wr_flit; // visible at head next cycle
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1; // head moves at the edge
			end
		end
	end

endmodule

/* src/flit_serializer.sv */
`timescale 1ns/100ps

module flit_serializer (
	input  logic            clk,
	input  logic            reset,
	// core side, held stable while word_valid
	input  noc_pkg::word_t  word_in,
	input  noc_pkg::route_t route_in,
	input  logic            last_in,      // word closes the packet
	input  logic            word_valid,
	output logic            word_ack,     // pulse on third flit write
	// transmit fifo side
	output noc_pkg::flit_t  flit_out,
	output logic            flit_wr,
	input  logic            flit_full
);
	import noc_pkg::*;

	ser_state_t state;
	ser_state_t next_state;
	logic       need_hdr;       // next word opens a packet
	logic       wr_done;        // flit accepted this cycle

	//////////////////////////////////////////////////////////////////////
	// write strobe and ack
	//////////////////////////////////////////////////////////////////////

	assign flit_wr  = (state != idle) && !flit_full;  // stall while full
	assign wr_done  = flit_wr;
	assign word_ack = (state == send_2) && wr_done;

	// flit mux, one payload per state
	always_comb begin
		flit_out.tail    = 1'b0;
		flit_out.payload = route_in;                  // header default
		case (state)
			send_0: flit_out.payload = word_in[2*payload_w +: payload_w];
			send_1: flit_out.payload = word_in[payload_w +: payload_w];
			send_2: begin
				flit_out.payload = word_in[0 +: payload_w];
				flit_out.tail    = last_in;           // only on last word
			end
			default: ;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// fsm
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (word_valid) begin
					next_state = need_hdr ? send_header : send_0;
				end
			end
			send_header: if (wr_done) next_state = send_0;
			send_0:      if (wr_done) next_state = send_1;
			send_1:      if (wr_done) next_state = send_2;
			send_2:      if (wr_done) next_state = idle;   // word closed
			default:     next_state = idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state    <= idle;
			need_hdr <= 1'b1;   // first word after reset opens a packet
		end else begin
			state <= next_state;
			if (state == send_header && wr_done) begin
				need_hdr <= 1'b0;
			end else if (word_ack) begin
				need_hdr <= last_in; // back to header after the last word
			end
		end
	end

endmodule

/* src/noc_pkg.sv */
package noc_pkg;

	//////////////////////////////////////////////////////////////////////
	// router flit format
	//
	//   [ tail | payload ]
	//      1       10
	//
	// header flit carries the route in the payload, tail always clear
	// data flit carries ten word bits, tail marks end of packet
	//////////////////////////////////////////////////////////////////////

	localparam int payload_w = 10;              // route or data bits per flit
	localparam int flit_w    = payload_w + 1;   // tail bit on top of payload

	//////////////////////////////////////////////////////////////////////
	// core word format
	//
	//   [ code | data ]
	//      8     24
	//
	// only the low 30 bits travel over the router
	//////////////////////////////////////////////////////////////////////

	localparam int word_w         = 32;
	localparam int code_w         = 8;          // top two bits are never routed
	localparam int flits_per_word = 3;          // msb flit first
	localparam int unrouted_w     = word_w - flits_per_word * payload_w; // = 2

	typedef struct packed {
		logic                 tail;             // last flit of packet
		logic [payload_w-1:0] payload;          // route (header) or data
	} flit_t;

	typedef logic [payload_w-1:0] route_t;      // destination in header payload
	typedef logic [word_w-1:0]    word_t;

	// receive side fsm
	typedef enum logic [2:0] {
		await_header,   // drop the header flit
		collect_0,      // word bits 29..20
		collect_1,      // word bits 19..10
		collect_2,      // word bits 9..0
		hold_word       // offer word to the core
	} deser_state_t;

	// transmit side fsm
	typedef enum logic [2:0] {
		idle,           // wait for a core word
		send_header,    // route flit
		send_0,
		send_1,
		send_2          // tail goes here on the last word
	} ser_state_t;

endpackage
